// ==== vlog.f ====
+incdir+.
rvPkg.sv
regFile.sv
controlUnit.sv
hazardUnit.sv
alu.sv
processor.sv
instrMem.sv
dataMem.sv
cpuSystem.sv
cpuSystem_assertions.sv
cpuSystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the cpuSystem testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module cpuSystem_tb -f vlog.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Run succeeded" \
    || { echo "Run failed"; exit 1; }

// ==== cpuSystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module cpuSystem_tb;
    import rvPkg::*;

    localparam int DmIdxW = $clog2(`DM_DEPTH);
    localparam int DirectedInstr = 59;
    localparam int RandomPrograms = 10;
    localparam int RandomBody = 16;
    localparam int RandomLen = RandomBody + 2;
    localparam int WatchdogCycles = 40 * (DirectedInstr + RandomPrograms * RandomLen);

    localparam int F3Add = 0;
    localparam int F3Slt = 2;
    localparam int F3Xor = 4;
    localparam int F3Or = 6;
    localparam int F3And = 7;
    localparam int F3Beq = 0;
    localparam int F3Bne = 1;
    localparam int F7Sub = 32;

    logic clk = 1'b0;
    logic rstN;
    logic startProcess;
    logic progWrite;
    word_t progAddr;
    word_t progData;
    logic endProcess;
    logic storeValid;
    word_t storeAddr;
    word_t storeData;

    word_t prog[$];
    word_t expAddr[$];
    word_t expData[$];
    word_t refRegs [`REG_COUNT];
    word_t refMem [`DM_DEPTH];
    word_t wantAddr;
    word_t wantData;
    int seed = 54;
    int mismatches = 0;
    int otherErrors = 0;

    cpuSystem uut (
        .clk(clk),
        .rstN(rstN),
        .startProcess(startProcess),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .endProcess(endProcess),
        .storeValid(storeValid),
        .storeAddr(storeAddr),
        .storeData(storeData)
    );

    always #4 clk = ~clk;

    // Instruction encoders
    function automatic void pushIType(int op, int f3, int rd, int rs1, int imm);
        prog.push_back({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]});
    endfunction

    function automatic void addi(int rd, int rs1, int imm);
        pushIType(int'(OP_IMM), 0, rd, rs1, imm);
    endfunction

    function automatic void lw(int rd, int rs1, int imm);
        pushIType(int'(LOAD), 2, rd, rs1, imm);
    endfunction

    function automatic void jalr(int rd, int rs1, int imm);
        pushIType(int'(JALR), 0, rd, rs1, imm);
    endfunction

    function automatic void sw(int rs2, int rs1, int imm);
        prog.push_back({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011});
    endfunction

    function automatic void aluReg(int f3, int f7, int rd, int rs1, int rs2);
        prog.push_back({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011});
    endfunction

    function automatic void branch(int f3, int rs1, int rs2, int off);
        prog.push_back({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                        7'b1100011});
    endfunction

    function automatic void lui(int rd, int upper);
        prog.push_back({upper[19:0], rd[4:0], 7'b0110111});
    endfunction

    function automatic void jal(int rd, int off);
        prog.push_back({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111});
    endfunction

    function automatic void ecall();
        prog.push_back(32'h0000_0073);
    endfunction

    // ISA interpreter, state persists across programs like the DUT
    function automatic void interpret();
        word_t pc;
        word_t nextPc;
        word_t ins;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t immI;
        word_t immS;
        word_t immB;
        word_t immJ;
        logic [2:0] f3;
        logic write;
        logic halted;
        int steps;
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 40 * prog.size()) begin
            if (int'(pc >> 2) >= prog.size()) begin
                $display("Reference model ran past the end of the program at pc %h", pc);
                otherErrors++;
                halted = 1'b1;
            end else begin
                ins = prog[pc >> 2];
                f3 = ins[14:12];
                a = refRegs[ins[19:15]];
                b = refRegs[ins[24:20]];
                immI = {{20{ins[31]}}, ins[31:20]};
                immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                nextPc = pc + 32'd4;
                res = '0;
                write = 1'b0;
                case (opcode_t'(ins[6:0]))
                    OP: begin
                        write = 1'b1;
                        case (f3)
                            3'd0: res = ins[30] ? a - b : a + b;
                            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            3'd4: res = a ^ b;
                            3'd6: res = a | b;
                            default: res = a & b;
                        endcase
                    end
                    OP_IMM: begin
                        write = 1'b1;
                        res = a + immI;
                    end
                    LUI: begin
                        write = 1'b1;
                        res = {ins[31:12], 12'b0};
                    end
                    LOAD: begin
                        write = 1'b1;
                        addr = a + immI;
                        res = refMem[addr[DmIdxW+1:2]];
                    end
                    STORE: begin
                        addr = a + immS;
                        refMem[addr[DmIdxW+1:2]] = b;
                        expAddr.push_back(addr);
                        expData.push_back(b);
                    end
                    BRANCH: begin
                        if ((a == b) != f3[0]) begin
                            nextPc = pc + immB;
                        end
                    end
                    JAL: begin
                        write = 1'b1;
                        res = pc + 32'd4;
                        nextPc = pc + immJ;
                    end
                    JALR: begin
                        write = 1'b1;
                        res = pc + 32'd4;
                        nextPc = (a + immI) & ~32'd1;
                    end
                    default: halted = 1'b1;
                endcase
                if (write && ins[11:7] != 5'd0) begin
                    refRegs[ins[11:7]] = res;
                end
                pc = nextPc;
                steps++;
            end
        end
    endfunction

    // Dependent chains hit forwarding from memory and writeback
    function automatic void buildAluChain();
        prog.delete();
        addi(1, 0, 5);
        addi(2, 1, -12);
        aluReg(F3Add, 0, 3, 1, 2);
        aluReg(F3Add, F7Sub, 4, 3, 1);
        aluReg(F3Slt, 0, 5, 4, 3);
        aluReg(F3Slt, 0, 6, 3, 4);
        aluReg(F3Xor, 0, 7, 5, 4);
        aluReg(F3And, 0, 8, 7, 2);
        aluReg(F3Or, 0, 9, 8, 1);
        lui(10, 'h12345);
        addi(10, 10, 'h678);
        addi(0, 0, 99);
        sw(3, 0, 0);
        sw(4, 0, 4);
        sw(5, 0, 8);
        sw(6, 0, 12);
        sw(9, 0, 16);
        sw(10, 0, 20);
        sw(0, 0, 24);
        addi(11, 10, 1);
        sw(11, 0, 28);
        ecall();
    endfunction

    function automatic void buildLoadUse();
        prog.delete();
        addi(1, 0, 100);
        sw(1, 0, 64);
        lw(2, 0, 64);
        addi(3, 2, 1);
        sw(3, 0, 68);
        lw(4, 0, 68);
        aluReg(F3Add, 0, 5, 4, 4);
        sw(5, 0, 72);
        lw(6, 0, 72);
        sw(6, 0, 76);
        lw(7, 0, 76);
        // Compare in decode right after the load
        branch(F3Beq, 7, 5, 8);
        sw(1, 0, 80);
        sw(7, 0, 84);
        ecall();
    endfunction

    // Skipped stores sit in the flushed slots
    function automatic void buildControlFlow();
        prog.delete();
        addi(1, 0, 3);
        addi(2, 0, 3);
        branch(F3Beq, 1, 2, 12);
        sw(1, 0, 100);
        sw(2, 0, 104);
        branch(F3Bne, 1, 2, 8);
        sw(1, 0, 108);
        addi(3, 0, 1);
        branch(F3Bne, 3, 1, 8);
        sw(3, 0, 112);
        branch(F3Beq, 3, 1, 8);
        jal(4, 12);
        sw(3, 0, 116);
        sw(3, 0, 120);
        sw(4, 0, 124);
        addi(5, 0, 76);
        jalr(6, 5, 4);
        sw(5, 0, 128);
        sw(5, 0, 132);
        sw(5, 0, 136);
        sw(6, 0, 140);
        ecall();
    endfunction

    function automatic void buildRandomProgram();
        int kind;
        int rd;
        int rs1;
        int rs2;
        prog.delete();
        rd = 1;
        for (int n = 0; n < RandomBody; n++) begin
            kind = $unsigned($random(seed)) % 5;
            rd = 1 + $unsigned($random(seed)) % 7;
            rs1 = $unsigned($random(seed)) % 8;
            rs2 = $unsigned($random(seed)) % 8;
            case (kind)
                0: addi(rd, rs1, $random(seed) % 2048);
                1: aluReg(F3Add, 0, rd, rs1, rs2);
                2: aluReg(F3Add, F7Sub, rd, rs1, rs2);
                3: aluReg(F3Xor, 0, rd, rs1, rs2);
                default: sw(rs2, 0, 512 + 4 * ($unsigned($random(seed)) % 64));
            endcase
        end
        sw(rd, 0, 508);
        ecall();
    endfunction

    task automatic loadProgram();
        foreach (prog[i]) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr <= word_t'(i * 4);
            progData <= prog[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
    endtask

    task automatic runProgram(input string name);
        int limit;
        int waited;
        limit = 40 * prog.size();
        loadProgram();
        interpret();
        @(posedge clk);
        startProcess <= 1'b1;
        @(posedge clk);
        startProcess <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!endProcess && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!endProcess) begin
            $display("Program %s: endProcess did not rise within %0d cycles", name, limit);
            otherErrors++;
        end
        // Core must stay halted
        repeat (6) begin
            @(negedge clk);
            if (!endProcess) begin
                $display("Program %s: endProcess fell while halted at %0t", name, $time);
                otherErrors++;
            end
        end
        if (expAddr.size() != 0) begin
            $display("Program %s: %0d expected stores never appeared", name, expAddr.size());
            otherErrors++;
            expAddr.delete();
            expData.delete();
        end
    endtask

    // Store stream against the interpreter
    always @(negedge clk) begin
        if (rstN && storeValid) begin
            if (expAddr.size() == 0) begin
                $display("Unexpected extra store at %0t: addr %h data %h",
                         $time, storeAddr, storeData);
                otherErrors++;
            end else begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                if (storeAddr !== wantAddr || storeData !== wantData) begin
                    $display("Mismatch at %0t: store expected addr %h data %h, got %h %h",
                             $time, wantAddr, wantData, storeAddr, storeData);
                    mismatches++;
                end
            end
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WatchdogCycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        startProcess = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < `DM_DEPTH; i++) begin
            refMem[i] = '0;
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // Idle after reset, nothing may be stored
        repeat (4) begin
            @(negedge clk);
            if (endProcess !== 1'b0 || storeValid !== 1'b0) begin
                $display("Core not idle after reset at %0t", $time);
                otherErrors++;
            end
        end

        buildAluChain();
        runProgram("aluChain");
        buildLoadUse();
        runProgram("loadUse");
        buildControlFlow();
        runProgram("controlFlow");
        for (int p = 0; p < RandomPrograms; p++) begin
            buildRandomProgram();
            runProgram($sformatf("random%0d", p));
        end

        $display("Errors: %0d mismatches, %0d other", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : cpuSystem_tb

`default_nettype wire

// ==== cpuSystem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem_assertions (
    input  wire  clk,
    input  wire  rstN,
    input  wire  startProcess,
    input  wire  endProcess,
    input  wire  memReadMem,
    input  wire  memWriteMem,
    input  wire  stall,
    input  wire  rvPkg::regName_t rs1EX,
    input  wire  rvPkg::regName_t rs2EX,
    input  wire  rvPkg::word_t fwd1,
    input  wire  rvPkg::word_t fwd2
);
    import rvPkg::*;

    // Data memory sees one access kind per cycle
    noReadWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(memReadMem && memWriteMem))
        else $error("memRead and memWrite high in the same cycle");

    // x0 operands reach execute as zero whatever was written to it
    zeroOp1: assert property (@(posedge clk) disable iff (!rstN)
        rs1EX == '0 |-> fwd1 == '0)
        else $error("x0 operand 1 in execute is nonzero");

    zeroOp2: assert property (@(posedge clk) disable iff (!rstN)
        rs2EX == '0 |-> fwd2 == '0)
        else $error("x0 operand 2 in execute is nonzero");

    // A load-use hazard costs a single bubble
    singleStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !stall)
        else $error("stall held for more than one cycle");

    // Halted until the next start pulse
    endHeld: assert property (@(posedge clk) disable iff (!rstN)
        endProcess && !startProcess |=> endProcess)
        else $error("endProcess dropped without startProcess");

endmodule : cpuSystem_assertions

bind processor cpuSystem_assertions checks (
    .clk(clk),
    .rstN(rstN),
    .startProcess(startProcess),
    .endProcess(endProcess),
    .memReadMem(memReadMem),
    .memWriteMem(memWriteMem),
    .stall(stall),
    .rs1EX(rs1EX),
    .rs2EX(rs2EX),
    .fwd1(fwd1),
    .fwd2(fwd2)
);

`default_nettype wire

// ==== cpuSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem (
    input  wire  clk,
    input  wire  rstN,
    input  wire  startProcess,
    input  wire  progWrite,
    input  wire  rvPkg::word_t progAddr,
    input  wire  rvPkg::word_t progData,
    output wire  endProcess,
    output wire  storeValid,
    output wire  rvPkg::word_t storeAddr,
    output wire  rvPkg::word_t storeData
);
    import rvPkg::*;

    word_t pcIF;
    word_t instructionIF;
    word_t dMOutMem;
    logic memReadMem;

    // Store port doubles as the data memory write side
    processor core (
        .clk,
        .rstN,
        .startProcess,
        .endProcess,
        .instructionIF,
        .pcIF,
        .dMOutMem,
        .memReadMem,
        .memWriteMem(storeValid),
        // Word-only data memory
        .func3Mem(),
        .aluOutMem(storeAddr),
        .rs2DataMem(storeData)
    );

    instrMem iMem (
        .clk,
        .progWrite,
        .progAddr,
        .progData,
        .addr(pcIF),
        .instruction(instructionIF)
    );

    dataMem dMem (
        .clk,
        .memRead(memReadMem),
        .memWrite(storeValid),
        .addr(storeAddr),
        .writeData(storeData),
        .readData(dMOutMem)
    );

endmodule : cpuSystem

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module dataMem (
    input  wire  clk,
    input  wire  memRead,
    input  wire  memWrite,
    input  wire  rvPkg::word_t addr,
    input  wire  rvPkg::word_t writeData,
    output rvPkg::word_t readData
);
    import rvPkg::*;

    localparam int IdxW = $clog2(`DM_DEPTH);

    // Starts out all zero
    word_t mem [`DM_DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[addr[IdxW+1:2]] <= writeData;
        end
    end

    assign readData = memRead ? mem[addr[IdxW+1:2]] : '0;

endmodule : dataMem

`default_nettype wire

// ==== instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module instrMem (
    input  wire  clk,
    input  wire  progWrite,
    input  wire  rvPkg::word_t progAddr,
    input  wire  rvPkg::word_t progData,
    input  wire  rvPkg::word_t addr,
    output rvPkg::word_t instruction
);
    import rvPkg::*;

    localparam int IdxW = $clog2(`IM_DEPTH);

    word_t mem [`IM_DEPTH];

    // progAddr is a byte address like the PC
    always_ff @(posedge clk) begin
        if (progWrite) begin
            mem[progAddr[IdxW+1:2]] <= progData;
        end
    end

    assign instruction = mem[addr[IdxW+1:2]];

endmodule : instrMem

`default_nettype wire

// ==== processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module processor (
    input  wire  clk,
    input  wire  rstN,
    input  wire  startProcess,
    output logic endProcess,
    input  wire  rvPkg::word_t instructionIF,
    output rvPkg::word_t pcIF,
    input  wire  rvPkg::word_t dMOutMem,
    output logic memReadMem,
    output logic memWriteMem,
    output logic [2:0] func3Mem,
    output rvPkg::word_t aluOutMem,
    output rvPkg::word_t rs2DataMem
);
    import rvPkg::*;

    logic running;

    // IF/ID
    logic validID;
    word_t pcID, instrID;

    // Decode
    regName_t rs1ID, rs2ID, rdID;
    logic [2:0] func3ID;
    logic jumpID, jumpRegID, branchID, haltID;
    logic memReadID, memWriteID, memToRegID, regWriteID;
    aluSrc1_t aluSrc1ID;
    aluSrc2_t aluSrc2ID;
    aluOp_t aluOpID;
    word_t immID, rs1DataID, rs2DataID;
    word_t cmp1, cmp2, jumpSum, jumpAddr;
    logic branchEq, takeBranch, stall, flush;

    // ID/EX
    logic regWriteEX, memReadEX, memWriteEX, memToRegEX, haltEX;
    aluSrc1_t aluSrc1EX;
    aluSrc2_t aluSrc2EX;
    aluOp_t aluOpEX;
    word_t pcEX, immEX, rs1DataEX, rs2DataEX;
    regName_t rs1EX, rs2EX, rdEX;
    logic [2:0] func3EX;
    forwardSel_t forward1, forward2;
    word_t fwd1, fwd2, aluA, aluB, aluResultEX;

    // EX/MEM and MEM/WB
    logic regWriteMem, memToRegMem, haltMem;
    regName_t rdMem;
    word_t memResult;
    logic regWriteWB, memToRegWB, haltWB;
    regName_t rdWB;
    word_t aluOutWB, dMOutWB, dataInWB;

    // PC and run state, PC frozen while idle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcIF <= '0;
            running <= 1'b0;
            endProcess <= 1'b0;
        end else if (startProcess) begin
            pcIF <= '0;
            running <= 1'b1;
            endProcess <= 1'b0;
        end else begin
            if (running && !stall) begin
                pcIF <= takeBranch ? jumpAddr : pcIF + word_t'(4);
            end
            if (haltID) begin
                running <= 1'b0;
            end
            // Halt has retired, older stores are done
            if (haltWB) begin
                endProcess <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validID <= 1'b0;
        end else if (!stall) begin
            validID <= running && !flush && !haltID;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcID <= pcIF;
            instrID <= instructionIF;
        end
    end

    assign rdID = instrID[11:7];
    assign func3ID = instrID[14:12];
    assign rs1ID = instrID[19:15];
    assign rs2ID = instrID[24:20];

    // A stalled slot decodes as a bubble
    controlUnit decoder (
        .instruction(instrID),
        .valid(validID && !stall),
        .jump(jumpID),
        .jumpReg(jumpRegID),
        .branch(branchID),
        .memRead(memReadID),
        .memWrite(memWriteID),
        .memToReg(memToRegID),
        .regWrite(regWriteID),
        .aluSrc1(aluSrc1ID),
        .aluSrc2(aluSrc2ID),
        .aluOp(aluOpID),
        .imm(immID),
        .halt(haltID)
    );

    regFile registers (
        .clk,
        .rstN,
        .wen(regWriteWB),
        .rs1(rs1ID),
        .rs2(rs2ID),
        .rd(rdWB),
        .dataIn(dataInWB),
        .rs1Data(rs1DataID),
        .rs2Data(rs2DataID)
    );

    // Operands for the decode-stage compare and JALR base
    function automatic word_t decodeBypass(regName_t rs, word_t regVal);
        if (rs != '0 && regWriteEX && rdEX == rs) begin
            return aluResultEX;
        end
        if (rs != '0 && regWriteMem && rdMem == rs) begin
            return memResult;
        end
        return regVal;
    endfunction

    always_comb begin
        cmp1 = decodeBypass(rs1ID, rs1DataID);
        cmp2 = decodeBypass(rs2ID, rs2DataID);
    end

    assign branchEq = cmp1 == cmp2;
    // func3[0] picks BNE over BEQ
    assign takeBranch = jumpID || jumpRegID ||
                        (branchID && (func3ID[0] ? !branchEq : branchEq));
    assign jumpSum = (jumpRegID ? cmp1 : pcID) + immID;
    assign jumpAddr = jumpRegID ? {jumpSum[31:1], 1'b0} : jumpSum;

    hazardUnit hazards (
        .rs1ID,
        .rs2ID,
        .rdEX,
        .memReadEX,
        .rs1EX,
        .rs2EX,
        .rdMem,
        .regWriteMem,
        .rdWB,
        .regWriteWB,
        .takeBranch,
        .stall,
        .flush,
        .forward1,
        .forward2
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteEX <= 1'b0;
            memReadEX <= 1'b0;
            memWriteEX <= 1'b0;
            memToRegEX <= 1'b0;
            haltEX <= 1'b0;
        end else begin
            regWriteEX <= regWriteID;
            memReadEX <= memReadID;
            memWriteEX <= memWriteID;
            memToRegEX <= memToRegID;
            haltEX <= haltID;
        end
    end

    always_ff @(posedge clk) begin
        aluSrc1EX <= aluSrc1ID;
        aluSrc2EX <= aluSrc2ID;
        aluOpEX <= aluOpID;
        pcEX <= pcID;
        immEX <= immID;
        rs1DataEX <= rs1DataID;
        rs2DataEX <= rs2DataID;
        rs1EX <= rs1ID;
        rs2EX <= rs2ID;
        rdEX <= rdID;
        func3EX <= func3ID;
    end

    function automatic word_t forwardMux(forwardSel_t sel, word_t regVal);
        case (sel)
            FWD_MEM: return aluOutMem;
            FWD_WB:  return dataInWB;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        fwd1 = forwardMux(forward1, rs1DataEX);
        fwd2 = forwardMux(forward2, rs2DataEX);
        aluA = (aluSrc1EX == SRC1_PC) ? pcEX : fwd1;
        case (aluSrc2EX)
            SRC2_IMM:  aluB = immEX;
            SRC2_FOUR: aluB = word_t'(4);
            default:   aluB = fwd2;
        endcase
    end

    alu execUnit (
        .a(aluA),
        .b(aluB),
        .op(aluOpEX),
        .result(aluResultEX)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteMem <= 1'b0;
            memReadMem <= 1'b0;
            memWriteMem <= 1'b0;
            memToRegMem <= 1'b0;
            haltMem <= 1'b0;
        end else begin
            regWriteMem <= regWriteEX;
            memReadMem <= memReadEX;
            memWriteMem <= memWriteEX;
            memToRegMem <= memToRegEX;
            haltMem <= haltEX;
        end
    end

    // Store data takes the forwarded rs2
    always_ff @(posedge clk) begin
        aluOutMem <= aluResultEX;
        rs2DataMem <= fwd2;
        rdMem <= rdEX;
        func3Mem <= func3EX;
    end

    assign memResult = memToRegMem ? dMOutMem : aluOutMem;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteWB <= 1'b0;
            memToRegWB <= 1'b0;
            haltWB <= 1'b0;
        end else begin
            regWriteWB <= regWriteMem;
            memToRegWB <= memToRegMem;
            haltWB <= haltMem;
        end
    end

    always_ff @(posedge clk) begin
        aluOutWB <= aluOutMem;
        dMOutWB <= dMOutMem;
        rdWB <= rdMem;
    end

    assign dataInWB = memToRegWB ? dMOutWB : aluOutWB;

endmodule : processor

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire  rvPkg::word_t a,
    input  wire  rvPkg::word_t b,
    input  wire  rvPkg::aluOp_t op,
    output rvPkg::word_t result
);
    import rvPkg::*;

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            // Signed compare, result is 0 or 1
            ALU_SLT:   result = word_t'($signed(a) < $signed(b));
            ALU_PASSB: result = b;
            default:   result = a + b;
        endcase
    end

endmodule : alu

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire  rvPkg::regName_t rs1ID,
    input  wire  rvPkg::regName_t rs2ID,
    input  wire  rvPkg::regName_t rdEX,
    input  wire  memReadEX,
    input  wire  rvPkg::regName_t rs1EX,
    input  wire  rvPkg::regName_t rs2EX,
    input  wire  rvPkg::regName_t rdMem,
    input  wire  regWriteMem,
    input  wire  rvPkg::regName_t rdWB,
    input  wire  regWriteWB,
    input  wire  takeBranch,
    output logic stall,
    output logic flush,
    output rvPkg::forwardSel_t forward1,
    output rvPkg::forwardSel_t forward2
);
    import rvPkg::*;

    // Load result is not ready until it leaves memory
    assign stall = memReadEX && rdEX != '0 && (rdEX == rs1ID || rdEX == rs2ID);
    assign flush = takeBranch;

    // Youngest producer wins
    function automatic forwardSel_t pickSource(regName_t rs);
        if (rs != '0 && regWriteMem && rdMem == rs) begin
            return FWD_MEM;
        end
        if (rs != '0 && regWriteWB && rdWB == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        forward1 = pickSource(rs1EX);
        forward2 = pickSource(rs2EX);
    end

endmodule : hazardUnit

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire  rvPkg::word_t instruction,
    input  wire  valid,
    output logic jump,
    output logic jumpReg,
    output logic branch,
    output logic memRead,
    output logic memWrite,
    output logic memToReg,
    output logic regWrite,
    output rvPkg::aluSrc1_t aluSrc1,
    output rvPkg::aluSrc2_t aluSrc2,
    output rvPkg::aluOp_t aluOp,
    output rvPkg::word_t imm,
    output logic halt
);
    import rvPkg::*;

    opcode_t opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    word_t immI, immS, immB, immU, immJ;

    assign opcode = opcode_t'(instruction[6:0]);
    assign func3 = instruction[14:12];
    assign func7 = instruction[31:25];

    // Sign-extended immediate forms
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        jump = 1'b0;
        jumpReg = 1'b0;
        branch = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        halt = 1'b0;
        aluSrc1 = SRC1_REG;
        aluSrc2 = SRC2_REG;
        aluOp = ALU_ADD;
        imm = immI;

        case (opcode)
            OP: begin
                regWrite = 1'b1;
                case (func3)
                    3'b000: aluOp = func7[5] ? ALU_SUB : ALU_ADD;
                    3'b010: aluOp = ALU_SLT;
                    3'b100: aluOp = ALU_XOR;
                    3'b110: aluOp = ALU_OR;
                    3'b111: aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            // Only ADDI in this subset
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc2 = SRC2_IMM;
            end
            LUI: begin
                regWrite = 1'b1;
                aluSrc2 = SRC2_IMM;
                aluOp = ALU_PASSB;
                imm = immU;
            end
            LOAD: begin
                regWrite = 1'b1;
                memRead = 1'b1;
                memToReg = 1'b1;
                aluSrc2 = SRC2_IMM;
            end
            STORE: begin
                memWrite = 1'b1;
                aluSrc2 = SRC2_IMM;
                imm = immS;
            end
            BRANCH: begin
                branch = 1'b1;
                imm = immB;
            end
            // Link value is PC + 4 computed in execute
            JAL: begin
                jump = 1'b1;
                regWrite = 1'b1;
                aluSrc1 = SRC1_PC;
                aluSrc2 = SRC2_FOUR;
                imm = immJ;
            end
            JALR: begin
                jumpReg = 1'b1;
                regWrite = 1'b1;
                aluSrc1 = SRC1_PC;
                aluSrc2 = SRC2_FOUR;
            end
            SYSTEM: halt = 1'b1;
            default: ;
        endcase

        // Bubble or flushed slot
        if (!valid) begin
            jump = 1'b0;
            jumpReg = 1'b0;
            branch = 1'b0;
            memRead = 1'b0;
            memWrite = 1'b0;
            regWrite = 1'b0;
            halt = 1'b0;
        end
    end

endmodule : controlUnit

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module regFile (
    input  wire  clk,
    input  wire  rstN,
    input  wire  wen,
    input  wire  rvPkg::regName_t rs1,
    input  wire  rvPkg::regName_t rs2,
    input  wire  rvPkg::regName_t rd,
    input  wire  rvPkg::word_t dataIn,
    output rvPkg::word_t rs1Data,
    output rvPkg::word_t rs2Data
);
    import rvPkg::*;

    word_t regs [`REG_COUNT];

    // Writes to x0 are dropped
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= dataIn;
        end
    end

    // Same-cycle write is visible to the reader
    function automatic word_t readPort(regName_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wen && rd == idx) begin
            return dataIn;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

endmodule : regFile

`default_nettype wire

// ==== rvPkg.sv ====
`default_nettype none
`include "rv_defines.svh"

package rvPkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] regName_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB
    } aluOp_t;

    typedef enum logic {SRC1_REG, SRC1_PC} aluSrc1_t;
    typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} aluSrc2_t;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} forwardSel_t;

endpackage : rvPkg

`default_nettype wire

// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and instruction width
`define XLEN 32

// Architectural registers x0..x31
`define REG_COUNT 32

// Memory depths in words
`define IM_DEPTH 256
`define DM_DEPTH 256

`endif
